//--- hw/pcd_tx_pkg.sv
// shared types and protocol constants for the ISO/IEC 14443 type A
// reader-side transmitter
package pcd_tx_pkg;

    // ----------------------------------------
    // modified Miller sequences
    // ----------------------------------------

    // X has its pause in the middle of the bit period, Z at the start,
    // and Y has no pause at all
    typedef enum logic [1:0] {
        SEQ_X,
        SEQ_Y,
        SEQ_Z
    } pcd_seq_e;

    // ----------------------------------------
    // host side
    // ----------------------------------------

    // command strobe from the host, add_crc is sampled with start
    typedef struct packed {
        logic start;
        logic add_crc;
    } tx_cmd_t;

    // one byte written into the frame buffer
    typedef struct packed {
        logic       strobe;
        logic [7:0] data;
    } buf_wr_t;

    // ----------------------------------------
    // serializer to encoder
    // ----------------------------------------

    // frame_end means every data, parity and CRC bit has gone out
    typedef struct packed {
        logic value;
        logic valid;
        logic frame_end;
    } tx_bit_t;

    // CRC_A preset from ISO/IEC 14443-3
    localparam logic [15:0] CRC_A_INIT = 16'h6363;

    // data bits per character, odd parity follows them
    localparam int CHAR_BITS = 8;

endpackage

//--- hw/frame_buffer.sv
// frame buffer for the type A transmitter
// collects host bytes and serves them to the serializer by index
`timescale 1ns/100ps

module frame_buffer
    import pcd_tx_pkg::*;
#(
    parameter int MAX_BYTES = 16
) (
    input  logic                           pcd_clk,
    input  logic                           reset,
    input  buf_wr_t                        wr,
    input  logic                           busy,
    input  logic                           clear,
    input  logic [$clog2(MAX_BYTES)-1:0]   rd_index,
    output logic [7:0]                     rd_data,
    output logic [$clog2(MAX_BYTES+1)-1:0] byte_count
);

    localparam int IDX_W = $clog2(MAX_BYTES);
    localparam int CNT_W = $clog2(MAX_BYTES + 1);

    logic [7:0]       mem [MAX_BYTES];
    logic [CNT_W-1:0] count;
    logic             wr_ok;

    // the buffer is frozen for the whole frame, and a full buffer
    // silently drops further bytes
    assign wr_ok = wr.strobe && !busy && (count < CNT_W'(MAX_BYTES));

    always_ff @(posedge pcd_clk) begin
        if (reset || clear) begin
            count <= '0;
        end else if (wr_ok) begin
            count <= count + 1'b1;
        end
    end

    // the next free slot is always at the current count
    always_ff @(posedge pcd_clk) begin
        if (wr_ok) begin
            mem[count[IDX_W-1:0]] <= wr.data;
        end
    end

    // zero latency read, the serializer picks the bit in the same cycle
    assign rd_data    = mem[rd_index];
    assign byte_count = count;

endmodule

//--- hw/crc_a.sv
// CRC_A generator, one byte per strobe
// ITU-T polynomial in reflected form, preset 6363 hex
`timescale 1ns/100ps

module crc_a
    import pcd_tx_pkg::*;
(
    input  logic        pcd_clk,
    input  logic        reset,
    input  logic        init,
    input  logic        crc_take,
    input  logic [7:0]  crc_byte,
    output logic [15:0] crc
);

    logic [7:0]  mix_a;
    logic [7:0]  mix_b;
    logic [15:0] crc_next;

    // byte-wise update as given in annex B of ISO/IEC 14443-3
    always_comb begin
        mix_a    = crc_byte ^ crc[7:0];
        mix_b    = mix_a ^ {mix_a[3:0], 4'd0};
        // shift the old value down a byte and fold in the mixed byte
        // at the three tap offsets of the reflected polynomial
        crc_next = {8'd0, crc[15:8]}
                 ^ {mix_b, 8'd0}
                 ^ {5'd0, mix_b, 3'd0}
                 ^ {12'd0, mix_b[7:4]};
    end

    // init wins over a take in the same cycle, a new frame always
    // starts from the preset
    always_ff @(posedge pcd_clk) begin
        if (reset || init) begin
            crc <= CRC_A_INIT;
        end else if (crc_take) begin
            crc <= crc_next;
        end
    end

endmodule

//--- hw/char_serializer.sv
// character serializer for the type A transmitter
// walks buffered bytes and then CRC_A, LSB first, odd parity after each byte
`timescale 1ns/100ps

module char_serializer
    import pcd_tx_pkg::*;
#(
    parameter int MAX_BYTES = 16
) (
    input  logic                           pcd_clk,
    input  logic                           reset,
    input  tx_cmd_t                        cmd,
    input  logic                           busy,
    input  logic [$clog2(MAX_BYTES+1)-1:0] byte_count,
    input  logic [7:0]                     rd_data,
    output logic [$clog2(MAX_BYTES)-1:0]   rd_index,
    input  logic [15:0]                    crc,
    output logic                           crc_take,
    output logic                           crc_init,
    output logic [7:0]                     crc_byte,
    input  logic                           bit_take,
    output tx_bit_t                        bit_out
);

    localparam int IDX_W = $clog2(MAX_BYTES);
    // byte position also covers the two CRC bytes after the data
    localparam int POS_W = $clog2(MAX_BYTES + 3);

    logic             add_crc_q;
    logic [POS_W-1:0] byte_pos;
    logic [3:0]       bit_pos;
    logic             done;
    logic [POS_W-1:0] data_bytes;
    logic [POS_W-1:0] total_bytes;
    logic             in_data;
    logic             last_byte;
    logic [7:0]       cur_byte;

    // ----------------------------------------
    // byte selection
    // ----------------------------------------

    assign data_bytes  = POS_W'(byte_count);
    assign total_bytes = data_bytes + (add_crc_q ? POS_W'(2) : POS_W'(0));
    assign in_data     = byte_pos < data_bytes;
    assign last_byte   = (byte_pos + 1'b1) == total_bytes;
    assign rd_index    = byte_pos[IDX_W-1:0];

    // CRC goes out low byte first, right after the last data byte
    always_comb begin
        if (in_data) begin
            cur_byte = rd_data;
        end else if (byte_pos == data_bytes) begin
            cur_byte = crc[7:0];
        end else begin
            cur_byte = crc[15:8];
        end
    end

    // ----------------------------------------
    // bit stream
    // ----------------------------------------

    // position CHAR_BITS is the parity slot, set so the nine bits hold
    // an odd number of ones
    always_comb begin
        bit_out.value     = (bit_pos == 4'(CHAR_BITS)) ? ~^cur_byte : cur_byte[bit_pos[2:0]];
        bit_out.valid     = busy && !done;
        bit_out.frame_end = busy && done;
    end

    // a data byte enters the CRC as its first bit is consumed, so the
    // CRC has settled long before its own bytes are reached
    assign crc_take = bit_take && (bit_pos == 4'd0) && in_data;
    assign crc_byte = rd_data;
    assign crc_init = cmd.start;

    always_ff @(posedge pcd_clk) begin
        if (reset) begin
            add_crc_q <= 1'b0;
            byte_pos  <= '0;
            bit_pos   <= '0;
            done      <= 1'b0;
        end else if (cmd.start) begin
            add_crc_q <= cmd.add_crc;
            byte_pos  <= '0;
            bit_pos   <= '0;
            done      <= 1'b0;
        end else if (bit_take) begin
            if (bit_pos == 4'(CHAR_BITS)) begin
                bit_pos <= '0;
                // parity of the final byte just left, nothing follows
                if (last_byte) begin
                    done <= 1'b1;
                end else begin
                    byte_pos <= byte_pos + 1'b1;
                end
            end else begin
                bit_pos <= bit_pos + 1'b1;
            end
        end
    end

endmodule

//--- hw/miller_encoder.sv
// modified Miller encoder for the type A transmitter
// maps each bit period onto sequence X, Y or Z and times the carrier pauses
`timescale 1ns/100ps

module miller_encoder
    import pcd_tx_pkg::*;
#(
    parameter int BIT_TICKS   = 128,
    parameter int PAUSE_TICKS = 32
) (
    input  logic    pcd_clk,
    input  logic    reset,
    input  logic    start,
    input  tx_bit_t bit_in,
    output logic    bit_take,
    output logic    clear,
    output logic    pause_n,
    output logic    sending,
    output logic    busy
);

    localparam int TICK_W = $clog2(BIT_TICKS);
    // pause offsets within the bit period
    localparam int X_PAUSE_AT = BIT_TICKS / 2;
    localparam int Z_PAUSE_AT = 0;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_END0,
        ST_ENDY
    } state_e;

    state_e            state;
    pcd_seq_e          cur_seq;
    logic [TICK_W-1:0] tick;
    logic              period_end;

    // a 1 is always X, a 0 is Y after an X and Z after anything else
    function automatic pcd_seq_e miller_code(input logic value, input pcd_seq_e prev);
        if (value) begin
            return SEQ_X;
        end else if (prev == SEQ_X) begin
            return SEQ_Y;
        end
        return SEQ_Z;
    endfunction

    // true while the tick lies inside a pause starting at first
    function automatic logic in_pause(input logic [TICK_W-1:0] t, input int first);
        return (int'(t) >= first) && (int'(t) < first + PAUSE_TICKS);
    endfunction

    // ----------------------------------------
    // bit period timing
    // ----------------------------------------

    assign period_end = (tick == TICK_W'(BIT_TICKS - 1));

    // each data period consumes its bit on tick 0, the value was already
    // coded into cur_seq at the period boundary
    assign bit_take = (state == ST_DATA) && (tick == '0) && bit_in.valid;

    // buffer empties on the same edge that drops busy
    assign clear = (state == ST_ENDY) && period_end;

    // ----------------------------------------
    // frame FSM
    // ----------------------------------------

    always_ff @(posedge pcd_clk) begin
        if (reset) begin
            state   <= ST_IDLE;
            cur_seq <= SEQ_Y;
            tick    <= '0;
        end else begin
            // the counter rests at zero while idle so the start Z begins
            // on tick 0
            if (state == ST_IDLE || period_end) begin
                tick <= '0;
            end else begin
                tick <= tick + 1'b1;
            end

            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state   <= ST_START;
                        cur_seq <= SEQ_Z;
                    end
                end
                ST_START, ST_DATA: begin
                    if (period_end) begin
                        // the end of communication is coded as a plain 0
                        if (bit_in.frame_end) begin
                            state   <= ST_END0;
                            cur_seq <= miller_code(1'b0, cur_seq);
                        end else begin
                            state   <= ST_DATA;
                            cur_seq <= miller_code(bit_in.value, cur_seq);
                        end
                    end
                end
                ST_END0: begin
                    if (period_end) begin
                        state   <= ST_ENDY;
                        cur_seq <= SEQ_Y;
                    end
                end
                ST_ENDY: begin
                    // cur_seq stays Y, which keeps the carrier on while idle
                    if (period_end) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ----------------------------------------
    // outputs
    // ----------------------------------------

    // pause_n is low while the carrier is switched off
    always_comb begin
        case (cur_seq)
            SEQ_X:   pause_n = !in_pause(tick, X_PAUSE_AT);
            SEQ_Z:   pause_n = !in_pause(tick, Z_PAUSE_AT);
            default: pause_n = 1'b1;
        endcase
    end

    assign busy    = (state != ST_IDLE);
    assign sending = (state inside {ST_START, ST_DATA, ST_END0, ST_ENDY});

endmodule

//--- hw/pcd_tx.sv
// ISO/IEC 14443 type A reader transmitter, top level
// host fills the buffer, a start strobe sends it Miller coded on pause_n
`timescale 1ns/100ps

module pcd_tx
    import pcd_tx_pkg::*;
#(
    parameter int BIT_TICKS   = 128,
    parameter int PAUSE_TICKS = 32,
    parameter int MAX_BYTES   = 16
) (
    input  logic    pcd_clk,
    input  logic    reset,
    input  buf_wr_t wr,
    input  tx_cmd_t cmd,
    output logic    pause_n,
    output logic    sending,
    output logic    busy
);

    logic [$clog2(MAX_BYTES+1)-1:0] byte_count;
    logic [$clog2(MAX_BYTES)-1:0]   rd_index;
    logic [7:0]                     rd_data;
    logic [15:0]                    crc;
    logic [7:0]                     crc_byte;
    logic                           crc_take;
    logic                           crc_init;
    logic                           start_ok;
    logic                           buf_busy;
    logic                           bit_take;
    logic                           clear;
    tx_cmd_t                        ser_cmd;
    tx_bit_t                        tx_bit;

    // a start only counts when idle and there is something to send
    assign start_ok = cmd.start && !busy && (byte_count != '0);

    // the buffer is frozen from the start cycle, so the frame on air is
    // what the host had written before the strobe
    assign buf_busy = busy || start_ok;

    assign ser_cmd.start   = start_ok;
    assign ser_cmd.add_crc = cmd.add_crc;

    frame_buffer #(
        .MAX_BYTES (MAX_BYTES)
    ) frame_buffer0 (
        .pcd_clk    (pcd_clk),
        .reset      (reset),
        .wr         (wr),
        .busy       (buf_busy),
        .clear      (clear),
        .rd_index   (rd_index),
        .rd_data    (rd_data),
        .byte_count (byte_count)
    );

    crc_a crc_a0 (
        .pcd_clk  (pcd_clk),
        .reset    (reset),
        .init     (crc_init),
        .crc_take (crc_take),
        .crc_byte (crc_byte),
        .crc      (crc)
    );

    char_serializer #(
        .MAX_BYTES (MAX_BYTES)
    ) char_serializer0 (
        .pcd_clk    (pcd_clk),
        .reset      (reset),
        .cmd        (ser_cmd),
        .busy       (busy),
        .byte_count (byte_count),
        .rd_data    (rd_data),
        .rd_index   (rd_index),
        .crc        (crc),
        .crc_take   (crc_take),
        .crc_init   (crc_init),
        .crc_byte   (crc_byte),
        .bit_take   (bit_take),
        .bit_out    (tx_bit)
    );

    miller_encoder #(
        .BIT_TICKS   (BIT_TICKS),
        .PAUSE_TICKS (PAUSE_TICKS)
    ) miller_encoder0 (
        .pcd_clk  (pcd_clk),
        .reset    (reset),
        .start    (start_ok),
        .bit_in   (tx_bit),
        .bit_take (bit_take),
        .clear    (clear),
        .pause_n  (pause_n),
        .sending  (sending),
        .busy     (busy)
    );

endmodule

//--- bench/clock_reset_gen.sv
// clock and reset source for the transmitter testbench
// free running pcd_clk, reset held high for a fixed number of cycles
`timescale 1ns/100ps

module clock_reset_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 10
) (
    output logic pcd_clk,
    output logic reset
);

    initial begin
        pcd_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) pcd_clk = ~pcd_clk;
    end

    // reset drops just after an edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge pcd_clk);
        #1 reset = 1'b0;
    end

endmodule

//--- bench/tb_pcd_tx.sv
// testbench for the type A reader transmitter
// random frames against a cycle accurate model of the Miller coded output
`timescale 1ns/100ps

module tb_pcd_tx
    import pcd_tx_pkg::*;
;

    localparam int BIT_TICKS   = 16;
    localparam int PAUSE_TICKS = 4;
    localparam int MAX_BYTES   = 16;
    // one frame of the largest size plus the writes and some slack
    localparam int FRAME_MAX   = (9 * MAX_BYTES + 3) * BIT_TICKS + MAX_BYTES + 8;
    localparam int FRAME_COUNT = 24;
    localparam int WATCHDOG_NS = (FRAME_COUNT * FRAME_MAX + 200) * 10;

    logic      pcd_clk;
    logic      reset;
    buf_wr_t   wr;
    tx_cmd_t   cmd;
    logic      pause_n;
    logic      sending;
    logic      busy;
    integer    seed;
    int        n_bytes;
    logic      add_crc;
    logic [15:0] crc_val;
    // bytes as they must appear on air including the CRC bytes
    logic [7:0] air_q[$];
    pcd_seq_e   seq_q[$];

    clock_reset_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (10)
    ) clock_reset_gen0 (
        .pcd_clk (pcd_clk),
        .reset   (reset)
    );

    pcd_tx #(
        .BIT_TICKS   (BIT_TICKS),
        .PAUSE_TICKS (PAUSE_TICKS),
        .MAX_BYTES   (MAX_BYTES)
    ) dut0 (
        .pcd_clk (pcd_clk),
        .reset   (reset),
        .wr      (wr),
        .cmd     (cmd),
        .pause_n (pause_n),
        .sending (sending),
        .busy    (busy)
    );

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, got %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "stopped at first error");
        end
    endtask

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    // bitwise CRC_A with the reflected polynomial 8408 hex over the first n bytes
    function automatic logic [15:0] crc_of_air(input int n);
        logic [15:0] c;
        c = CRC_A_INIT;
        for (int i = 0; i < n; i++) begin
            c = c ^ {8'd0, air_q[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 16'h8408) : (c >> 1);
            end
        end
        return c;
    endfunction

    // in the modified Miller rule a 0 after an X is the only Y inside a frame
    function automatic pcd_seq_e miller_next(input logic value, input pcd_seq_e prev);
        if (value) begin
            return SEQ_X;
        end
        return (prev == SEQ_X) ? SEQ_Y : SEQ_Z;
    endfunction

    function automatic logic pause_expect(input pcd_seq_e s, input int t);
        case (s)
            SEQ_X:   return !((t >= BIT_TICKS / 2) && (t < BIT_TICKS / 2 + PAUSE_TICKS));
            SEQ_Z:   return !(t < PAUSE_TICKS);
            default: return 1'b1;
        endcase
    endfunction

    // the frame opens with a start Z and has nine periods per byte with the
    // odd parity last, then the end 0 and a final Y
    task automatic build_seq();
        pcd_seq_e prev;
        logic     v;
        seq_q.delete();
        seq_q.push_back(SEQ_Z);
        prev = SEQ_Z;
        foreach (air_q[i]) begin
            for (int b = 0; b < 9; b++) begin
                v = (b < 8) ? air_q[i][b] : ~^air_q[i];
                prev = miller_next(v, prev);
                seq_q.push_back(prev);
            end
        end
        seq_q.push_back(miller_next(1'b0, prev));
        seq_q.push_back(SEQ_Y);
    endtask

    task automatic check_idle();
        check("pause_n", 1, pause_n);
        check("sending", 0, sending);
        check("busy", 0, busy);
    endtask

    // ----------------------------------------
    // frame driver and checker
    // ----------------------------------------

    // writes the first n_write bytes of air_q, starts the frame and follows it
    // cycle by cycle
    // with disturb set it also hammers writes and starts while busy
    task automatic run_frame(input int n_write, input logic crc_on, input logic disturb);
        int total;
        build_seq();
        total = seq_q.size() * BIT_TICKS;
        for (int k = 0; k < n_write; k++) begin
            wr.strobe = 1'b1;
            wr.data   = air_q[k];
            @(posedge pcd_clk);
            #1;
        end
        // a write in the start cycle itself must be dropped as well
        wr.strobe   = disturb;
        wr.data     = $random(seed);
        cmd.start   = 1'b1;
        cmd.add_crc = crc_on;
        @(posedge pcd_clk);
        #1;
        for (int k = 0; k < total; k++) begin
            check("pause_n", pause_expect(seq_q[k / BIT_TICKS], k % BIT_TICKS), pause_n);
            check("sending", 1, sending);
            check("busy", 1, busy);
            if (disturb && k < total - 1) begin
                wr.strobe   = $random(seed);
                wr.data     = $random(seed);
                cmd.start   = $random(seed);
                cmd.add_crc = $random(seed);
            end else begin
                wr.strobe = 1'b0;
                cmd.start = 1'b0;
            end
            @(posedge pcd_clk);
            #1;
        end
        check_idle();
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the transmitter did not finish its frames in time");
        $display("tests failed");
        $fatal(1, "stopped by watchdog");
    end

    initial begin
        seed = 32'hbf8f_15c7;
        wr   = '0;
        cmd  = '0;
        @(negedge reset);
        @(posedge pcd_clk);
        #1;

        // the DUT is idle after reset and a start with nothing buffered does nothing
        check_idle();
        cmd.start = 1'b1;
        @(posedge pcd_clk);
        #1;
        cmd.start = 1'b0;
        repeat (2 * BIT_TICKS) begin
            check_idle();
            @(posedge pcd_clk);
            #1;
        end

        // one fixed byte gives twelve bit periods on air
        air_q = '{8'h5a};
        run_frame(1, 1'b0, 1'b0);

        // writes and starts while busy leave the frame on air unchanged
        air_q = '{8'hc3, 8'h01, 8'hff};
        run_frame(3, 1'b0, 1'b1);

        // known CRC_A values from the standard
        air_q = '{8'h00, 8'h00, 8'ha0, 8'h1e};
        run_frame(2, 1'b1, 1'b0);
        air_q = '{8'h12, 8'h34, 8'h26, 8'hcf};
        run_frame(2, 1'b1, 1'b0);

        // random lengths, contents and CRC flag
        for (int f = 0; f < 20; f++) begin
            n_bytes = 1 + ($unsigned($random(seed)) % (MAX_BYTES - 2));
            add_crc = $random(seed);
            air_q.delete();
            for (int i = 0; i < n_bytes; i++) begin
                air_q.push_back($random(seed));
            end
            if (add_crc) begin
                crc_val = crc_of_air(n_bytes);
                air_q.push_back(crc_val[7:0]);
                air_q.push_back(crc_val[15:8]);
            end
            run_frame(n_bytes, add_crc, 1'b0);
        end

        $display("all tests passed");
        $finish;
    end

endmodule

//--- compile.f
hw/pcd_tx_pkg.sv
hw/frame_buffer.sv
hw/crc_a.sv
hw/char_serializer.sv
hw/miller_encoder.sv
hw/pcd_tx.sv
bench/clock_reset_gen.sv
bench/tb_pcd_tx.sv
